/* Makefile */
# Verilator flow for the pipeline control subsystem
OBJ_DIR = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module pipe_ctrl_top -f pipe_ctrl_top.f

sim:
	verilator --binary --timing --assert --top-module pipe_ctrl_tb \
		-f pipe_ctrl_top.f --Mdir $(OBJ_DIR) -o pipe_ctrl_sim
	./$(OBJ_DIR)/pipe_ctrl_sim

clean:
	rm -rf $(OBJ_DIR)

/* hw/hazard_unit.sv */
// ========================================
// pipeline hazard unit
// ========================================
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
    input  logic                  dren,          // load in memory stage
    input  logic                  dwen,          // store in memory stage
    input  logic                  d_mem_busy,
    input  logic                  i_mem_busy,
    input  logic                  jump,
    input  logic                  branch,
    input  logic                  mispredict,
    input  logic                  ex_busy,       // multi-cycle op in execute
    input  logic                  halt,
    input  logic                  fence_stall,
    input  logic                  ifence,
    input  logic                  mret,
    input  logic                  intr_pending,  // already gated by mie
    input  logic                  insert_pc,     // trap unit redirect
    input  logic                  valid_e,
    input  logic                  valid_m,
    input  pipe_ctrl_pkg::exc_vec_t exc_flags,
    input  pipe_ctrl_pkg::word_t  pc_f,
    input  pipe_ctrl_pkg::word_t  pc_e,
    input  pipe_ctrl_pkg::word_t  pc_m,
    output logic                  pc_en,
    output logic                  npc_sel,
    output logic                  if_ex_stall,
    output logic                  if_ex_flush,
    output logic                  ex_mem_stall,
    output logic                  ex_mem_flush,
    output logic                  suppress_iren,
    output logic                  suppress_data,
    output logic                  exception,
    output logic                  intr_take,
    output pipe_ctrl_pkg::word_t  epc
);

    logic wait_for_imem;
    logic wait_for_dmem;
    logic branch_jump;
    logic flush_hazard; // control hazard from trap, return or fence

    assign branch_jump = jump || (branch && mispredict);
    assign npc_sel     = branch_jump; // fall through is pc + 4

    // exceptions win over interrupts in the same cycle
    assign exception = |exc_flags;
    assign intr_take = intr_pending && !exception;

    // no point waiting on a fetch or data access that is about to be thrown away
    assign suppress_iren = branch_jump || flush_hazard || insert_pc;
    assign suppress_data = exception; // keep a faulting access off the bus

    assign wait_for_imem = i_mem_busy && !suppress_iren;
    assign wait_for_dmem = (dren || dwen) && d_mem_busy && !suppress_data;

    // an interrupt lets a pending data access finish first
    assign flush_hazard = exception
                       || (intr_take && !wait_for_dmem)
                       || mret
                       || (ifence && !fence_stall); // refetch after the fence drains

    // memory side stalls freeze the whole pipe
    assign ex_mem_stall = wait_for_dmem || fence_stall || halt;

    // a busy execute stage gives way to a redirect
    assign if_ex_stall = ex_mem_stall
                      || fence_stall
                      || (ex_busy && !flush_hazard && !branch_jump);

    assign if_ex_flush = flush_hazard
                      || branch_jump
                      || (wait_for_imem && !ex_mem_stall); // bubble while fetch lags

    // bubble into memory while execute holds its instruction
    assign ex_mem_flush = flush_hazard || (if_ex_stall && !ex_mem_stall);

    // pc moves when fetch can hand off or when something forces a redirect
    assign pc_en = (!if_ex_stall && !wait_for_imem)
                || branch_jump
                || flush_hazard
                || insert_pc
                || mret;

    // oldest valid instruction owns the trap
    // a plain interrupt lets the memory stage instruction retire
    assign epc = (valid_m && (!intr_take || branch_jump)) ? pc_m :
                 (valid_e ? pc_e : pc_f);

    always_comb begin
        assert (!(ex_mem_stall && ex_mem_flush))
            else $error("ex_mem stall and flush both high");
    end

endmodule

`default_nettype wire

/* hw/pipe_ctrl_pkg.sv */
// ========================================
// pipeline control shared types
// ========================================
`default_nettype none

package pipe_ctrl_pkg;

    typedef logic [31:0] word_t;   // pc or address
    typedef logic [3:0]  cause_t;  // mcause code without the interrupt flag
    typedef logic [8:0]  exc_vec_t; // one flag per exception source

    localparam word_t RESET_PC    = 32'h0000_1000; // first fetch address
    localparam word_t TRAP_VECTOR = 32'h0000_0100; // single handler entry

    // exc_vec_t bit positions, bit 0 wins
    localparam int unsigned EXC_FAULT_INSN = 0;
    localparam int unsigned EXC_MAL_INSN   = 1;
    localparam int unsigned EXC_ILLEGAL    = 2;
    localparam int unsigned EXC_BREAK      = 3;
    localparam int unsigned EXC_MAL_L      = 4;
    localparam int unsigned EXC_FAULT_L    = 5;
    localparam int unsigned EXC_MAL_S      = 6;
    localparam int unsigned EXC_FAULT_S    = 7;
    localparam int unsigned EXC_ENV        = 8;

    // standard risc-v exception codes
    localparam cause_t CAUSE_MAL_INSN   = 4'd0;
    localparam cause_t CAUSE_FAULT_INSN = 4'd1;
    localparam cause_t CAUSE_ILLEGAL    = 4'd2;
    localparam cause_t CAUSE_BREAK      = 4'd3;
    localparam cause_t CAUSE_MAL_L      = 4'd4;
    localparam cause_t CAUSE_FAULT_L    = 4'd5;
    localparam cause_t CAUSE_MAL_S      = 4'd6;
    localparam cause_t CAUSE_FAULT_S    = 4'd7;
    localparam cause_t CAUSE_ENV        = 4'd11; // ecall from machine mode

    // no room for the interrupt flag in 4 bits
    // so a reserved code marks an interrupt entry
    localparam cause_t CAUSE_INTR = 4'hf;

endpackage

`default_nettype wire

/* hw/pipe_ctrl_top.sv */
// ========================================
// pipeline control top
// ========================================
`timescale 1ns/10ps
`default_nettype none

module pipe_ctrl_top (
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    dren,
    input  logic                    dwen,
    input  logic                    d_mem_busy,
    input  logic                    i_mem_busy,
    input  logic                    jump,
    input  logic                    branch,
    input  logic                    mispredict,
    input  pipe_ctrl_pkg::word_t    branch_target,
    input  logic                    ex_busy,
    input  logic                    halt,
    input  logic                    fence_stall,
    input  logic                    ifence,
    input  pipe_ctrl_pkg::exc_vec_t exc_flags,
    input  logic                    intr_req,
    input  logic                    mret,
    output pipe_ctrl_pkg::word_t    pc_f,
    output pipe_ctrl_pkg::word_t    pc_e,
    output pipe_ctrl_pkg::word_t    pc_m,
    output logic                    valid_e,
    output logic                    valid_m,
    output logic                    if_ex_stall,
    output logic                    if_ex_flush,
    output logic                    ex_mem_stall,
    output logic                    ex_mem_flush,
    output logic                    suppress_iren,
    output logic                    suppress_data,
    output pipe_ctrl_pkg::word_t    mepc,
    output pipe_ctrl_pkg::cause_t   mcause
);
    import pipe_ctrl_pkg::*;

    logic  pc_en;
    logic  npc_sel;
    logic  exception;
    logic  intr_take;
    logic  intr_pending;
    logic  insert_pc;
    word_t epc;
    word_t priv_pc;    // trap vector or return address

    hazard_unit u_hazard (
        .dren          (dren),
        .dwen          (dwen),
        .d_mem_busy    (d_mem_busy),
        .i_mem_busy    (i_mem_busy),
        .jump          (jump),
        .branch        (branch),
        .mispredict    (mispredict),
        .ex_busy       (ex_busy),
        .halt          (halt),
        .fence_stall   (fence_stall),
        .ifence        (ifence),
        .mret          (mret),
        .intr_pending  (intr_pending),
        .insert_pc     (insert_pc),
        .valid_e       (valid_e),
        .valid_m       (valid_m),
        .exc_flags     (exc_flags),
        .pc_f          (pc_f),
        .pc_e          (pc_e),
        .pc_m          (pc_m),
        .pc_en         (pc_en),
        .npc_sel       (npc_sel),
        .if_ex_stall   (if_ex_stall),
        .if_ex_flush   (if_ex_flush),
        .ex_mem_stall  (ex_mem_stall),
        .ex_mem_flush  (ex_mem_flush),
        .suppress_iren (suppress_iren),
        .suppress_data (suppress_data),
        .exception     (exception),
        .intr_take     (intr_take),
        .epc           (epc)
    );

    trap_unit u_trap (
        .CLK          (CLK),
        .rst          (rst),
        .exception    (exception),
        .intr_take    (intr_take),
        .intr_req     (intr_req),
        .mret         (mret),
        .exc_flags    (exc_flags),
        .epc          (epc),
        .intr_pending (intr_pending),
        .insert_pc    (insert_pc),
        .priv_pc      (priv_pc),
        .mepc         (mepc),
        .mcause       (mcause)
    );

    stage_pc_track u_track (
        .CLK           (CLK),
        .rst           (rst),
        .pc_en         (pc_en),
        .npc_sel       (npc_sel),
        .insert_pc     (insert_pc),
        .if_ex_stall   (if_ex_stall),
        .if_ex_flush   (if_ex_flush),
        .ex_mem_stall  (ex_mem_stall),
        .ex_mem_flush  (ex_mem_flush),
        .branch_target (branch_target),
        .priv_pc       (priv_pc),
        .pc_f          (pc_f),
        .pc_e          (pc_e),
        .pc_m          (pc_m),
        .valid_e       (valid_e),
        .valid_m       (valid_m)
    );

endmodule

`default_nettype wire

/* hw/stage_pc_track.sv */
// ========================================
// stage pc tracker
// ========================================
`timescale 1ns/10ps
`default_nettype none

module stage_pc_track (
    input  logic                 CLK,
    input  logic                 rst,
    input  logic                 pc_en,
    input  logic                 npc_sel,       // take branch_target
    input  logic                 insert_pc,     // take priv_pc, beats npc_sel
    input  logic                 if_ex_stall,
    input  logic                 if_ex_flush,
    input  logic                 ex_mem_stall,
    input  logic                 ex_mem_flush,
    input  pipe_ctrl_pkg::word_t branch_target,
    input  pipe_ctrl_pkg::word_t priv_pc,
    output pipe_ctrl_pkg::word_t pc_f,
    output pipe_ctrl_pkg::word_t pc_e,
    output pipe_ctrl_pkg::word_t pc_m,
    output logic                 valid_e,
    output logic                 valid_m
);
    import pipe_ctrl_pkg::*;

    // index 0 is execute, index 1 is memory
    word_t      pc_q     [2];
    word_t      pc_in    [2];
    logic [1:0] valid_q;
    logic [1:0] valid_in;
    logic [1:0] stall;
    logic [1:0] flush;
    word_t      pc_next;

    assign pc_next = insert_pc ? priv_pc :
                     npc_sel   ? branch_target :
                                 pc_f + 32'd4;

    // fetch pc only moves when the hazard unit allows it
    always_ff @(posedge CLK) begin
        if (rst)
            pc_f <= RESET_PC;
        else if (pc_en)
            pc_f <= pc_next;
    end

    // fetch always hands over a live instruction
    assign pc_in[0]    = pc_f;
    assign valid_in[0] = 1'b1;
    assign pc_in[1]    = pc_q[0];
    assign valid_in[1] = valid_q[0];

    assign stall = {ex_mem_stall, if_ex_stall};
    assign flush = {ex_mem_flush, if_ex_flush};

    // same boundary logic for both stages
    always_ff @(posedge CLK) begin
        for (int i = 0; i < 2; i++) begin
            if (rst) begin
                valid_q[i] <= 1'b0;
                pc_q[i]    <= '0;
            end else begin
                if (flush[i])
                    valid_q[i] <= 1'b0;        // bubble wins over hold
                else if (!stall[i])
                    valid_q[i] <= valid_in[i];
                if (!stall[i])
                    pc_q[i] <= pc_in[i];       // pc of a bubble is don't care
            end
        end
    end

    assign pc_e    = pc_q[0];
    assign pc_m    = pc_q[1];
    assign valid_e = valid_q[0];
    assign valid_m = valid_q[1];

endmodule

`default_nettype wire

/* hw/trap_unit.sv */
// ========================================
// trap and return unit
// ========================================
`timescale 1ns/10ps
`default_nettype none

module trap_unit (
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    exception,    // any exception flag this cycle
    input  logic                    intr_take,
    input  logic                    intr_req,     // raw request from the core
    input  logic                    mret,
    input  pipe_ctrl_pkg::exc_vec_t exc_flags,
    input  pipe_ctrl_pkg::word_t    epc,          // chosen by the hazard unit
    output logic                    intr_pending,
    output logic                    insert_pc,
    output pipe_ctrl_pkg::word_t    priv_pc,
    output pipe_ctrl_pkg::word_t    mepc,
    output pipe_ctrl_pkg::cause_t   mcause
);
    import pipe_ctrl_pkg::*;

    logic   mie;        // global interrupt enable
    logic   mpie;       // enable saved across a trap
    logic   trap;
    cause_t trap_cause;

    assign intr_pending = intr_req && mie;
    assign trap         = exception || intr_take;

    // redirect goes out in the same cycle as the trap
    assign insert_pc = trap || mret;
    assign priv_pc   = mret ? mepc : TRAP_VECTOR;

    // lowest flag wins
    always_comb begin
        trap_cause = CAUSE_INTR; // nothing flagged means interrupt
        if (exc_flags[EXC_FAULT_INSN])
            trap_cause = CAUSE_FAULT_INSN;
        else if (exc_flags[EXC_MAL_INSN])
            trap_cause = CAUSE_MAL_INSN;
        else if (exc_flags[EXC_ILLEGAL])
            trap_cause = CAUSE_ILLEGAL;
        else if (exc_flags[EXC_BREAK])
            trap_cause = CAUSE_BREAK;
        else if (exc_flags[EXC_MAL_L])
            trap_cause = CAUSE_MAL_L;
        else if (exc_flags[EXC_FAULT_L])
            trap_cause = CAUSE_FAULT_L;
        else if (exc_flags[EXC_MAL_S])
            trap_cause = CAUSE_MAL_S;
        else if (exc_flags[EXC_FAULT_S])
            trap_cause = CAUSE_FAULT_S;
        else if (exc_flags[EXC_ENV])
            trap_cause = CAUSE_ENV;
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            mepc   <= '0;
            mcause <= '0;
            mie    <= 1'b1; // interrupts on out of reset
            mpie   <= 1'b1;
        end else if (trap) begin
            mepc   <= epc;
            mcause <= trap_cause;
            mpie   <= mie;
            mie    <= 1'b0; // no nesting until mret
        end else if (mret) begin
            mie    <= mpie;
            mpie   <= 1'b1;
        end
    end

    // a returning instruction cannot also fault in the same cycle
    property p_mret_not_with_exception;
        @(posedge CLK) disable iff (rst)
        !(mret && exception);
    endproperty
    a_mret_not_with_exception: assert property (p_mret_not_with_exception)
        else $error("mret together with exception");

endmodule

`default_nettype wire

/* pipe_ctrl_top.f */
hw/pipe_ctrl_pkg.sv
hw/hazard_unit.sv
hw/trap_unit.sv
hw/stage_pc_track.sv
hw/pipe_ctrl_top.sv
verif/pipe_ctrl_tb.sv

/* verif/pipe_ctrl_tb.sv */
// ========================================
// pipeline control testbench
// ========================================
`timescale 1ns/10ps
`default_nettype none

module pipe_ctrl_tb;
    import pipe_ctrl_pkg::*;

    localparam int    CLK_HALF     = 5;   // 10 ns period
    localparam int    SAMPLE_DELAY = 9;   // just before the next rising edge
    localparam int    MARGIN       = 20;  // extra cycles allowed past the vectors
    localparam string VEC_FILE     = "verif/pipe_ctrl_vectors.txt";

    logic     CLK;
    logic     rst;
    logic     dren, dwen, d_mem_busy, i_mem_busy;
    logic     jump, branch, mispredict;
    logic     ex_busy, halt, fence_stall, ifence;
    logic     intr_req, mret;
    exc_vec_t exc_flags;
    word_t    branch_target;

    word_t    pc_f, pc_e, pc_m;
    logic     valid_e, valid_m;
    logic     if_ex_stall, if_ex_flush, ex_mem_stall, ex_mem_flush;
    logic     suppress_iren, suppress_data;
    word_t    mepc;
    cause_t   mcause;

    // one entry per vector line
    logic [12:0] vin_q[$];    // packed control inputs
    exc_vec_t    vexc_q[$];
    word_t       vtgt_q[$];
    logic [5:0]  vctl_q[$];   // expected stall, flush and suppress bits
    word_t       vpcf_q[$];
    word_t       vpce_q[$];
    word_t       vpcm_q[$];
    logic [1:0]  vval_q[$];   // {valid_e, valid_m}
    word_t       vmepc_q[$];
    cause_t      vcause_q[$];

    int cycle_count = 0;
    int cycle_limit = MARGIN;

    pipe_ctrl_top u_dut (
        .CLK           (CLK),
        .rst           (rst),
        .dren          (dren),
        .dwen          (dwen),
        .d_mem_busy    (d_mem_busy),
        .i_mem_busy    (i_mem_busy),
        .jump          (jump),
        .branch        (branch),
        .mispredict    (mispredict),
        .branch_target (branch_target),
        .ex_busy       (ex_busy),
        .halt          (halt),
        .fence_stall   (fence_stall),
        .ifence        (ifence),
        .exc_flags     (exc_flags),
        .intr_req      (intr_req),
        .mret          (mret),
        .pc_f          (pc_f),
        .pc_e          (pc_e),
        .pc_m          (pc_m),
        .valid_e       (valid_e),
        .valid_m       (valid_m),
        .if_ex_stall   (if_ex_stall),
        .if_ex_flush   (if_ex_flush),
        .ex_mem_stall  (ex_mem_stall),
        .ex_mem_flush  (ex_mem_flush),
        .suppress_iren (suppress_iren),
        .suppress_data (suppress_data),
        .mepc          (mepc),
        .mcause        (mcause)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_HALF) CLK = ~CLK;
    end

    // run limit, scaled by the vector count once the file is read
    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
            $display("Testbench failed");
            $fatal(1, "control bit mismatch");
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            $display("Testbench failed");
            $fatal(1, "pc mismatch");
        end
    endtask

    task automatic check_cause(input string name, input cause_t exp, input cause_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            $display("Testbench failed");
            $fatal(1, "cause mismatch");
        end
    endtask

    task automatic read_vectors();
        int          fd;
        int          code;
        string       line;
        logic [12:0] f_in;
        exc_vec_t    f_exc;
        word_t       f_tgt, f_pcf, f_pce, f_pcm, f_mepc;
        logic [5:0]  f_ctl;
        logic [1:0]  f_val;
        cause_t      f_cause;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", VEC_FILE);
            $display("Testbench failed");
            $fatal(1, "missing vector file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.substr(0, 0) == "#")
                    continue; // blank or comment
                code = $sscanf(line, "%b %h %h %b %h %h %h %b %h %h", f_in, f_exc, f_tgt,
                               f_ctl, f_pcf, f_pce, f_pcm, f_val, f_mepc, f_cause);
                if (code != 10) begin
                    $display("vector line has %0d fields instead of 10: %s", code, line);
                    $display("Testbench failed");
                    $fatal(1, "bad vector line");
                end else begin
                    vin_q.push_back(f_in);
                    vexc_q.push_back(f_exc);
                    vtgt_q.push_back(f_tgt);
                    vctl_q.push_back(f_ctl);
                    vpcf_q.push_back(f_pcf);
                    vpce_q.push_back(f_pce);
                    vpcm_q.push_back(f_pcm);
                    vval_q.push_back(f_val);
                    vmepc_q.push_back(f_mepc);
                    vcause_q.push_back(f_cause);
                end
            end
            $fclose(fd);
        end
    endtask

    // applied on the rising edge, seen by the flops at the next one
    task automatic drive_line(input int i);
        {dren, dwen, d_mem_busy, i_mem_busy, jump, branch, mispredict,
         ex_busy, halt, fence_stall, ifence, intr_req, mret} <= vin_q[i];
        exc_flags     <= vexc_q[i];
        branch_target <= vtgt_q[i];
    endtask

    task automatic check_line(input int i);
        check_bit("if_ex_stall", vctl_q[i][5], if_ex_stall);
        check_bit("if_ex_flush", vctl_q[i][4], if_ex_flush);
        check_bit("ex_mem_stall", vctl_q[i][3], ex_mem_stall);
        check_bit("ex_mem_flush", vctl_q[i][2], ex_mem_flush);
        check_bit("suppress_iren", vctl_q[i][1], suppress_iren);
        check_bit("suppress_data", vctl_q[i][0], suppress_data);
        check_word("pc_f", vpcf_q[i], pc_f);
        check_word("pc_e", vpce_q[i], pc_e);
        check_word("pc_m", vpcm_q[i], pc_m);
        check_bit("valid_e", vval_q[i][1], valid_e);
        check_bit("valid_m", vval_q[i][0], valid_m);
        check_word("mepc", vmepc_q[i], mepc);
        check_cause("mcause", vcause_q[i], mcause);
    endtask

    initial begin
        void'($urandom(32'h4c9a0ace));
        rst <= 1'b1;
        {dren, dwen, d_mem_busy, i_mem_busy, jump, branch, mispredict,
         ex_busy, halt, fence_stall, ifence, intr_req, mret} <= '0;
        exc_flags     <= '0;
        branch_target <= '0;
        read_vectors();
        cycle_limit = vin_q.size() + MARGIN;
        repeat (4) @(posedge CLK);
        rst <= 1'b0; // line 0 starts from the reset state
        for (int i = 0; i < vin_q.size(); i++) begin
            if (i > 0)
                @(posedge CLK);
            drive_line(i);
            #(SAMPLE_DELAY);
            check_line(i);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/pipe_ctrl_vectors.txt */
# in: dren dwen dbusy ibusy jump branch misp exbusy halt fstall ifence intr mret | exc | target
# exp: ifx_stall ifx_flush exm_stall exm_flush sup_iren sup_data | pc_f pc_e pc_m | {ve,vm} | mepc | mcause
# state columns show the registers before this line's inputs take effect
0000000000000 000 00000000 000000 00001000 00000000 00000000 00 00000000 0
0000000000000 000 00000000 000000 00001004 00001000 00000000 10 00000000 0
0000000000000 000 00000000 000000 00001008 00001004 00001000 11 00000000 0
0000000000000 000 00000000 000000 0000100c 00001008 00001004 11 00000000 0
1010000000000 000 00000000 101000 00001010 0000100c 00001008 11 00000000 0
1010000000000 000 00000000 101000 00001010 0000100c 00001008 11 00000000 0
0001000000000 000 00000000 010000 00001010 0000100c 00001008 11 00000000 0
0000000000000 000 00000000 000000 00001010 00001010 0000100c 01 00000000 0
0000000000000 000 00000000 000000 00001014 00001010 00001010 10 00000000 0
0000011000000 000 00002000 010010 00001018 00001014 00001010 11 00000000 0
0000000000000 000 00000000 000000 00002000 00001018 00001014 01 00000000 0
0000100000000 000 00003000 010010 00002004 00002000 00001018 10 00000000 0
0000000000000 000 00000000 000000 00003000 00002004 00002000 01 00000000 0
0000000000000 000 00000000 000000 00003004 00003000 00002004 10 00000000 0
0000000000000 004 00000000 010111 00003008 00003004 00003000 11 00000000 0
0000000000000 000 00000000 000000 00000100 00003008 00003004 00 00003000 2
0000000000001 000 00000000 010110 00000104 00000100 00003008 10 00003000 2
0000100000000 000 00005000 010010 00003000 00000104 00000100 00 00003000 2
0000000000000 000 00000000 000000 00005000 00003000 00000104 00 00003000 2
0000000000010 000 00000000 010110 00005004 00005000 00003000 10 00003000 2
0000000000010 000 00000000 000000 00000100 00005004 00005000 00 00005000 f
0000000000000 000 00000000 000000 00000104 00000100 00005004 10 00005000 f
0000000000001 000 00000000 010110 00000108 00000104 00000100 11 00005000 f
0000000000000 000 00000000 000000 00005000 00000108 00000104 00 00005000 f
0000100100000 000 00006000 010010 00005004 00005000 00000108 10 00005000 f
0000000000000 000 00000000 000000 00006000 00005004 00005000 01 00005000 f
0000000000000 000 00000000 000000 00006004 00006000 00005004 10 00005000 f
0000000100000 000 00000000 100100 00006008 00006004 00006000 11 00005000 f
0000000100000 000 00000000 100100 00006008 00006004 00006004 10 00005000 f
0000000000000 000 00000000 000000 00006008 00006004 00006004 10 00005000 f
0000000000000 000 00000000 000000 0000600c 00006008 00006004 11 00005000 f
